/* bench/exChecker.sv */
`timescale 1ns/10ps

module exChecker import mipsExPkg::*; #(
    parameter int MulBitsPerCycle = 4
) (
    input  logic        clk,
    input  logic        rstN,
    input  exReqT       req,
    input  exResT       res,
    input  logic        stall,
    input  exResT       expRes,
    input  logic [95:0] expName,
    output int          errorCount,
    output int          checkCount
);

    localparam int Steps = 32 / MulBitsPerCycle;

    int stallCycles;  // Stall cycles seen for the request now on the port.

    // Everything is sampled half a cycle after the bench drives, when the
    // combinational result has settled.
    always @(negedge clk) begin
        if (!rstN) begin
            errorCount  = 0;
            checkCount  = 0;
            stallCycles = 0;
        end else if (!req.valid) begin
            if (stall) begin
                $display("Stall is high while no valid request is presented.");
                errorCount++;
            end
            if (res !== '0) begin
                $display("The result is not all zero while valid is low.");
                errorCount++;
            end
        end else if (stall) begin
            stallCycles++;
            if (!isMulOp(req.op)) begin
                $display("Stall is high on the non-multiply test %s.", expName);
                errorCount++;
            end
        end else begin
            // ============================================================
            // Retire cycle
            // ============================================================
            checkCount++;
            if (res !== expRes) begin
                $display("ERROR %s: expected value=%h ovf=%b trap=%b, actual value=%h ovf=%b trap=%b",
                         expName, expRes.value, expRes.overflow, expRes.trap,
                         res.value, res.overflow, res.trap);
                errorCount++;
            end
            if (isMulOp(req.op) && stallCycles != Steps) begin
                $display("Multiply test %s stalled for %0d cycles instead of %0d.",
                         expName, stallCycles, Steps);
                errorCount++;
            end
            stallCycles = 0;
        end
    end

endmodule

/* bench/exStageTb.sv */
`timescale 1ns/10ps

module exStageTb import mipsExPkg::*; ();

    localparam int MulBitsPerCycle = 4;
    localparam int Steps           = 32 / MulBitsPerCycle;

    typedef struct packed {
        logic [95:0] name;
        aluOpT       op;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sa;
        exResT       exp;
    } testT;

    logic        clk;
    logic        rstN;
    exReqT       req;
    exResT       res;
    logic        stall;
    exResT       expRes;
    logic [95:0] expName;
    int          errorCount;
    int          checkCount;
    testT        tests[$];
    logic [31:0] lcgState;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    exStage #(
        .MulBitsPerCycle (MulBitsPerCycle)
    ) dut_i (
        .clk   (clk),
        .rstN  (rstN),
        .req   (req),
        .res   (res),
        .stall (stall)
    );

    exChecker #(
        .MulBitsPerCycle (MulBitsPerCycle)
    ) checker_i (
        .clk        (clk),
        .rstN       (rstN),
        .req        (req),
        .res        (res),
        .stall      (stall),
        .expRes     (expRes),
        .expName    (expName),
        .errorCount (errorCount),
        .checkCount (checkCount)
    );

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState ^ (lcgState >> 16);
    endfunction

    // Names are padded with spaces to twelve characters.
    task automatic addTest(input string name, input aluOpT op, input logic [31:0] a,
                           input logic [31:0] b, input logic [4:0] sa,
                           input logic [31:0] value, input logic [1:0] flags);
        testT t;
        for (int k = 0; k < 12; k++) begin
            t.name[8*(11-k) +: 8] = (k < name.len()) ? name[k] : 8'h20;
        end
        t.op  = op;
        t.a   = a;
        t.b   = b;
        t.sa  = sa;
        t.exp = '{value, flags[1], flags[0]};  // Flags are {overflow, trap}.
        tests.push_back(t);
    endtask

    // ============================================================
    // Stimulus table
    // ============================================================

    task automatic addFixedTests();
        addTest("mfhi reset", OpMfhi, 32'h00000000, 32'h00000000, 5'd0, 32'h00000000, 2'b00);
        addTest("mflo reset", OpMflo, 32'h00000000, 32'h00000000, 5'd0, 32'h00000000, 2'b00);
        addTest("and",        OpAnd,  32'hF0F0FF00, 32'h0FF0F0F0, 5'd0, 32'h00F0F000, 2'b00);
        addTest("or",         OpOr,   32'hF0F0FF00, 32'h0FF0F0F0, 5'd0, 32'hFFF0FFF0, 2'b00);
        addTest("nor",        OpNor,  32'hF0F0FF00, 32'h0FF0F0F0, 5'd0, 32'h000F000F, 2'b00);
        addTest("xor",        OpXor,  32'hF0F0FF00, 32'h0FF0F0F0, 5'd0, 32'hFF000FF0, 2'b00);
        addTest("add",        OpAdd,  32'h00000005, 32'hFFFFFFFD, 5'd0, 32'h00000002, 2'b00);
        addTest("add ovf",    OpAdd,  32'h7FFFFFFF, 32'h00000001, 5'd0, 32'h80000000, 2'b10);
        addTest("addu",       OpAddu, 32'h7FFFFFFF, 32'h00000001, 5'd0, 32'h80000000, 2'b00);
        addTest("sub ovf",    OpSub,  32'h80000000, 32'h00000001, 5'd0, 32'h7FFFFFFF, 2'b10);
        addTest("subu",       OpSubu, 32'h80000000, 32'h00000001, 5'd0, 32'h7FFFFFFF, 2'b00);
        addTest("slt",        OpSlt,  32'hFFFFFFFF, 32'h00000001, 5'd0, 32'h00000001, 2'b00);
        addTest("sltu",       OpSltu, 32'hFFFFFFFF, 32'h00000001, 5'd0, 32'h00000000, 2'b00);
        addTest("sllv",       OpSllv, 32'h00000004, 32'h00000011, 5'd0, 32'h00000110, 2'b00);
        addTest("srlv",       OpSrlv, 32'h00000004, 32'h80000000, 5'd0, 32'h08000000, 2'b00);
        addTest("srav",       OpSrav, 32'h00000004, 32'h80000000, 5'd0, 32'hF8000000, 2'b00);
        addTest("sll",        OpSll,  32'h00000000, 32'h80000001, 5'd1, 32'h00000002, 2'b00);
        addTest("srl",        OpSrl,  32'h00000000, 32'h80000000, 5'd31, 32'h00000001, 2'b00);
        addTest("sra",        OpSra,  32'h00000000, 32'h80000000, 5'd31, 32'hFFFFFFFF, 2'b00);
        addTest("lui",        OpLui,  32'h00000000, 32'h00001234, 5'd0, 32'h12340000, 2'b00);
        addTest("clo none",   OpClo,  32'h00000000, 32'h00000000, 5'd0, 32'h00000000, 2'b00);
        addTest("clo mid",    OpClo,  32'hFF000000, 32'h00000000, 5'd0, 32'h00000008, 2'b00);
        addTest("clo all",    OpClo,  32'hFFFFFFFF, 32'h00000000, 5'd0, 32'h00000020, 2'b00);
        addTest("clz all",    OpClz,  32'h00000000, 32'h00000000, 5'd0, 32'h00000020, 2'b00);
        addTest("clz mid",    OpClz,  32'h00010000, 32'h00000000, 5'd0, 32'h0000000F, 2'b00);
        addTest("clz none",   OpClz,  32'h80000000, 32'h00000000, 5'd0, 32'h00000000, 2'b00);
        addTest("movn",       OpMovn, 32'hDEADBEEF, 32'h00000001, 5'd0, 32'hDEADBEEF, 2'b00);
        addTest("movn zero",  OpMovn, 32'hDEADBEEF, 32'h00000000, 5'd0, 32'h00000000, 2'b00);
        addTest("movz",       OpMovz, 32'hDEADBEEF, 32'h00000001, 5'd0, 32'h00000000, 2'b00);
        addTest("movz zero",  OpMovz, 32'hDEADBEEF, 32'h00000000, 5'd0, 32'hDEADBEEF, 2'b00);
        addTest("teq",        OpTeq,  32'h00000005, 32'h00000005, 5'd0, 32'h00000000, 2'b01);
        addTest("tne",        OpTne,  32'h00000005, 32'h00000005, 5'd0, 32'h00000000, 2'b00);
        addTest("tge",        OpTge,  32'hFFFFFFFF, 32'h00000001, 5'd0, 32'h00000000, 2'b00);
        addTest("tgeu",       OpTgeu, 32'hFFFFFFFF, 32'h00000001, 5'd0, 32'h00000000, 2'b01);
        addTest("tlt",        OpTlt,  32'hFFFFFFFF, 32'h00000001, 5'd0, 32'h00000000, 2'b01);
        addTest("tltu",       OpTltu, 32'hFFFFFFFF, 32'h00000001, 5'd0, 32'h00000000, 2'b00);
        addTest("mthi",       OpMthi, 32'hCAFEF00D, 32'h00000000, 5'd0, 32'h00000000, 2'b00);
        addTest("mtlo",       OpMtlo, 32'h12345678, 32'h00000000, 5'd0, 32'h00000000, 2'b00);
        addTest("mt hi",      OpMfhi, 32'h00000000, 32'h00000000, 5'd0, 32'hCAFEF00D, 2'b00);
        addTest("mt lo",      OpMflo, 32'h00000000, 32'h00000000, 5'd0, 32'h12345678, 2'b00);
        addTest("mul neg",    OpMul,  32'hFFFFFFFD, 32'h00000007, 5'd0, 32'hFFFFFFEB, 2'b00);
        addTest("mul max",    OpMul,  32'h7FFFFFFF, 32'h7FFFFFFF, 5'd0, 32'h00000001, 2'b00);
        addTest("mult",       OpMult, 32'hFFFFFFFE, 32'h00000003, 5'd0, 32'h00000000, 2'b00);
        addTest("mult hi",    OpMfhi, 32'h00000000, 32'h00000000, 5'd0, 32'hFFFFFFFF, 2'b00);
        addTest("mult lo",    OpMflo, 32'h00000000, 32'h00000000, 5'd0, 32'hFFFFFFFA, 2'b00);
        addTest("multu",      OpMultu, 32'hFFFFFFFF, 32'hFFFFFFFF, 5'd0, 32'h00000000, 2'b00);
        addTest("multu hi",   OpMfhi, 32'h00000000, 32'h00000000, 5'd0, 32'hFFFFFFFE, 2'b00);
        addTest("multu lo",   OpMflo, 32'h00000000, 32'h00000000, 5'd0, 32'h00000001, 2'b00);
    endtask

    task automatic addRandomTests();
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] ext;
        logic [32:0] borrow;
        lcgState = 32'd854;
        for (int i = 0; i < 32; i++) begin
            a = nextRand();
            b = nextRand();
            case (i % 4)
                0: addTest("rand addu", OpAddu, a, b, 5'd0, a + b, 2'b00);
                1: addTest("rand xor", OpXor, a, b, 5'd0, a ^ b, 2'b00);
                2: begin
                    borrow = {1'b0, a} - {1'b0, b};  // A borrow out means a is below b.
                    addTest("rand sltu", OpSltu, a, b, 5'd0, {31'b0, borrow[32]}, 2'b00);
                end
                default: begin
                    ext = {{32{b[31]}}, b} >> a[4:0];  // Sign fill from the upper word.
                    addTest("rand srav", OpSrav, a, b, 5'd0, ext[31:0], 2'b00);
                end
            endcase
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        rstN    <= 1'b0;
        req     <= '0;
        expRes  <= '0;
        expName <= '0;
        addFixedTests();
        addRandomTests();
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < tests.size(); i++) begin
            @(posedge clk);
            req     <= '{1'b1, tests[i].op, tests[i].a, tests[i].b, tests[i].sa};
            expRes  <= tests[i].exp;
            expName <= tests[i].name;
            @(negedge clk);
            while (stall) begin
                @(negedge clk);  // Request is held until the stage lets it go.
            end
        end
        @(posedge clk);
        req <= '0;
        repeat (2) @(posedge clk);
        $display("Summary: %0d of %0d tests retired, %0d errors",
                 checkCount, tests.size(), errorCount);
        if (errorCount == 0 && checkCount == tests.size()) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog sized from the table length and the multiply latency.
    initial begin
        int cycles;
        int limit;
        cycles = 0;
        @(posedge rstN);
        limit = tests.size() * (Steps + 4) + 50;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the stage did not retire every test.", cycles);
        $display("tests failed");
        $finish;
    end

endmodule

/* bench/exStage_sva.sv */
`timescale 1ns/10ps

module exStageSva import mipsExPkg::*; #(
    parameter int MulBitsPerCycle = 4
) (
    input logic  clk,
    input logic  rstN,
    input exReqT req,
    input logic  stall,
    input logic  mulBusy,
    input logic  mulDone
);

    localparam int Steps = 32 / MulBitsPerCycle;

    int stallRun;  // Consecutive stall cycles before the current one.

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stallRun <= 0;
        end else if (stall) begin
            stallRun <= stallRun + 1;
        end else begin
            stallRun <= 0;
        end
    end

    resetIdle: assert property (@(posedge clk)
        $rose(rstN) |-> !stall && !mulBusy && !mulDone)
        else $error("The stage is not idle in the first cycle after reset.");

    // A new multiply request finds the multiplier idle and stalls at once.
    mulStartStall: assert property (@(posedge clk) disable iff (!rstN)
        req.valid && isMulOp(req.op) && !$past(stall) |-> stall)
        else $error("Stall did not rise in the first cycle of a multiply request.");

    // Stall may last at most one cycle more than the multiplier's step count.
    boundedStall: assert property (@(posedge clk) disable iff (!rstN)
        stall |-> stallRun <= Steps)
        else $error("Stall stayed high longer than %0d cycles.", Steps + 1);

endmodule

bind exStage exStageSva #(
    .MulBitsPerCycle (MulBitsPerCycle)
) sva_i (
    .clk     (clk),
    .rstN    (rstN),
    .req     (req),
    .stall   (stall),
    .mulBusy (mulBusy),
    .mulDone (mulDone)
);

/* compile.f */
source/mipsExPkg.sv
source/aluCore.sv
source/iterMultiplier.sv
source/hiLoReg.sv
source/exStage.sv
bench/exChecker.sv
bench/exStage_sva.sv
bench/exStageTb.sv

/* run.sh */
#!/bin/sh
# Build the execute-stage testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module exStageTb -o simv

out=$(./obj_dir/simv)
echo "$out"

if echo "$out" | grep -q "all tests passed"; then
    exit 0
else
    exit 1
fi

/* source/aluCore.sv */
`timescale 1ns/10ps

module aluCore import mipsExPkg::*; (
    input  exReqT       req,
    input  logic [63:0] mulProd,
    input  logic [63:0] hiLo,
    output exResT       res
);

    // Counts how many bits from the MSB down match bitVal before the first mismatch.
    function automatic logic [31:0] leadCount(logic [31:0] x, logic bitVal);
        logic [31:0] cnt;
        logic        stop;
        cnt  = '0;
        stop = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (!stop && x[i] == bitVal) begin
                cnt = cnt + 32'd1;
            end else begin
                stop = 1'b1;
            end
        end
        return cnt;
    endfunction

    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sum;
    logic [31:0] diff;
    logic [31:0] value;
    logic        overflow;
    logic        trap;

    assign a    = req.srcA;
    assign b    = req.srcB;
    assign sum  = a + b;
    assign diff = a - b;

    // ============================================================
    // Result and overflow
    // ============================================================

    always_comb begin
        overflow = 1'b0;
        case (req.op)
            OpAnd:  value = a & b;
            OpOr:   value = a | b;
            OpNor:  value = ~(a | b);
            OpXor:  value = a ^ b;

            OpAdd: begin
                value    = sum;
                overflow = (a[31] == b[31]) && (sum[31] != a[31]); // Like signs, new sign.
            end
            OpAddu: value = sum;
            OpSub: begin
                value    = diff;
                overflow = (a[31] != b[31]) && (diff[31] != a[31]);
            end
            OpSubu: value = diff;

            OpSlt:  value = {31'b0, $signed(a) < $signed(b)};
            OpSltu: value = {31'b0, a < b};

            // Variable shifts take the amount from the low bits of srcA.
            OpSllv: value = b << a[4:0];
            OpSrlv: value = b >> a[4:0];
            OpSrav: value = $signed(b) >>> a[4:0];
            OpSll:  value = b << req.sa;
            OpSrl:  value = b >> req.sa;
            OpSra:  value = $signed(b) >>> req.sa;

            OpLui:  value = {b[15:0], 16'b0};

            OpMfhi: value = hiLo[63:32];
            OpMflo: value = hiLo[31:0];

            OpClo:  value = leadCount(a, 1'b1);
            OpClz:  value = leadCount(a, 1'b0);

            OpMovn: value = (|b) ? a : 32'b0;
            OpMovz: value = (|b) ? 32'b0 : a;

            OpMul:  value = mulProd[31:0];  // Low word of the signed product.

            OpTeq, OpTge, OpTgeu, OpTlt, OpTltu, OpTne: begin
                value = 32'b0;
            end

            OpNop:  value = a;

            // MULT, MULTU, MTHI and MTLO only touch HI/LO.
            default: value = 32'b0;
        endcase
    end

    // ============================================================
    // Trap conditions
    // ============================================================

    always_comb begin
        case (req.op)
            OpTeq:   trap = a == b;
            OpTge:   trap = $signed(a) >= $signed(b);
            OpTgeu:  trap = a >= b;
            OpTlt:   trap = $signed(a) < $signed(b);
            OpTltu:  trap = a < b;
            OpTne:   trap = a != b;
            default: trap = 1'b0;
        endcase
    end

    // An empty slot reports nothing at all.
    always_comb begin
        res = '0;
        if (req.valid) begin
            res.value    = value;
            res.overflow = overflow;
            res.trap     = trap;
        end
    end

endmodule

/* source/exStage.sv */
`timescale 1ns/10ps

module exStage import mipsExPkg::*; #(
    parameter int MulBitsPerCycle = 4
) (
    input  logic  clk,
    input  logic  rstN,
    input  exReqT req,
    output exResT res,
    output logic  stall
);

    logic        mulReq;
    logic        mulBusy;
    logic        mulDone;
    logic        retire;
    logic [63:0] product;
    logic [63:0] hiLo;

    // ============================================================
    // Stall and retire
    // ============================================================

    // Busy covers the working cycles and ~done the request cycle before the
    // multiplier has started. Upstream holds req while this is high.
    assign mulReq = req.valid && isMulOp(req.op);
    assign stall  = mulReq && (mulBusy || !mulDone);
    assign retire = req.valid && !stall;

    // ============================================================
    // Blocks
    // ============================================================

    aluCore aluCore_i (
        .req     (req),
        .mulProd (product),
        .hiLo    (hiLo),
        .res     (res)
    );

    iterMultiplier #(
        .MulBitsPerCycle (MulBitsPerCycle)
    ) iterMultiplier_i (
        .clk     (clk),
        .rstN    (rstN),
        .req     (req),
        .advance (retire),
        .busy    (mulBusy),
        .done    (mulDone),
        .product (product)
    );

    // MULT, MULTU, MTHI and MTLO land here on the retire edge.
    hiLoReg hiLoReg_i (
        .clk     (clk),
        .rstN    (rstN),
        .req     (req),
        .retire  (retire),
        .product (product),
        .hiLo    (hiLo)
    );

endmodule

/* source/hiLoReg.sv */
`timescale 1ns/10ps

module hiLoReg import mipsExPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  exReqT       req,
    input  logic        retire,
    input  logic [63:0] product,
    output logic [63:0] hiLo
);

    logic [31:0] hi;
    logic [31:0] lo;
    logic        mulWr;
    logic        hiWe;
    logic        loWe;
    logic [31:0] hiNext;
    logic [31:0] loNext;

    // Write-port selection.
    assign mulWr  = retire && (req.op == OpMult || req.op == OpMultu);
    assign hiWe   = mulWr || (retire && req.op == OpMthi);
    assign loWe   = mulWr || (retire && req.op == OpMtlo);
    assign hiNext = mulWr ? product[63:32] : req.srcA;
    assign loNext = mulWr ? product[31:0]  : req.srcA;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hi <= 32'b0;
            lo <= 32'b0;
        end else begin
            if (hiWe) begin
                hi <= hiNext;
            end
            if (loWe) begin
                lo <= loNext;
            end
        end
    end

    assign hiLo = {hi, lo};

endmodule

/* source/iterMultiplier.sv */
`timescale 1ns/10ps

module iterMultiplier import mipsExPkg::*; #(
    parameter int MulBitsPerCycle = 4
) (
    input  logic        clk,
    input  logic        rstN,
    input  exReqT       req,
    input  logic        advance,
    output logic        busy,
    output logic        done,
    output logic [63:0] product
);

    localparam int Steps = 32 / MulBitsPerCycle;
    localparam int CntW  = $clog2(Steps);

    logic            signedOp;
    logic            start;
    logic [31:0]     magA;
    logic [31:0]     magB;
    logic            negIn;
    logic [31:0]     mcand;
    logic [31:0]     mplier;
    logic            negRes;
    logic [63:0]     acc;
    logic [CntW-1:0] count;
    logic [31:0]     stepMcand;
    logic [31:0]     stepMplier;
    logic [63:0]     stepAcc;
    logic [63:0]     stepSum;
    logic [CntW-1:0] stepCount;
    logic            stepNeg;
    logic            lastStep;

    assign signedOp = req.op != OpMultu;  // MUL and MULT are signed.
    assign start    = req.valid && isMulOp(req.op) && !busy && !done;

    // Work on magnitudes and restore the sign after the last step.
    assign magA  = (signedOp && req.srcA[31]) ? -req.srcA : req.srcA;
    assign magB  = (signedOp && req.srcB[31]) ? -req.srcB : req.srcB;
    assign negIn = signedOp && (req.srcA[31] ^ req.srcB[31]);

    // The first step runs straight from the request so the op fits in Steps cycles.
    assign stepMcand  = busy ? mcand  : magA;
    assign stepMplier = busy ? mplier : magB;
    assign stepAcc    = busy ? acc    : 64'b0;
    assign stepCount  = busy ? count  : '0;
    assign stepNeg    = busy ? negRes : negIn;
    assign lastStep   = stepCount == CntW'(Steps - 1);

    always_comb begin
        stepSum = stepAcc;
        for (int i = 0; i < MulBitsPerCycle; i++) begin
            if (stepMplier[i]) begin
                stepSum = stepSum
                        + ({32'b0, stepMcand} << (int'(stepCount) * MulBitsPerCycle + i));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else if (start || busy) begin
            count <= stepCount + 1'b1;
            busy  <= !lastStep;
            done  <= lastStep;
        end else if (done && advance) begin
            done <= 1'b0;  // Product consumed by the retiring op.
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            mplier <= stepMplier >> MulBitsPerCycle;
            acc    <= (lastStep && stepNeg) ? -stepSum : stepSum;
            if (start) begin
                mcand  <= magA;
                negRes <= negIn;
            end
        end
    end

    assign product = acc;

endmodule

/* source/mipsExPkg.sv */
package mipsExPkg;

    // ============================================================
    // ALU operation codes
    // ============================================================

    // Immediate trap forms share the register codes since the
    // immediate is already placed on srcB by decode.
    typedef enum logic [7:0] {
        OpNop   = 8'h00,
        OpAnd   = 8'h01,
        OpOr    = 8'h02,
        OpNor   = 8'h03,
        OpXor   = 8'h04,
        OpAdd   = 8'h10,
        OpAddu  = 8'h11,
        OpSub   = 8'h12,
        OpSubu  = 8'h13,
        OpSlt   = 8'h18,
        OpSltu  = 8'h19,
        OpSllv  = 8'h20,
        OpSrlv  = 8'h21,
        OpSrav  = 8'h22,
        OpSll   = 8'h23,
        OpSrl   = 8'h24,
        OpSra   = 8'h25,
        OpLui   = 8'h28,
        OpMfhi  = 8'h30,
        OpMflo  = 8'h31,
        OpMthi  = 8'h32,
        OpMtlo  = 8'h33,
        OpClo   = 8'h38,
        OpClz   = 8'h39,
        OpMovn  = 8'h3a,
        OpMovz  = 8'h3b,
        OpMul   = 8'h40,
        OpMult  = 8'h41,
        OpMultu = 8'h42,
        OpTeq   = 8'h50,
        OpTge   = 8'h51,
        OpTgeu  = 8'h52,
        OpTlt   = 8'h53,
        OpTltu  = 8'h54,
        OpTne   = 8'h55
    } aluOpT;

    // ============================================================
    // Stage request and result
    // ============================================================

    typedef struct packed {
        logic        valid;
        aluOpT       op;
        logic [31:0] srcA;
        logic [31:0] srcB;
        logic [4:0]  sa;    // Shift amount for SLL, SRL and SRA.
    } exReqT;

    typedef struct packed {
        logic [31:0] value;
        logic        overflow;
        logic        trap;
    } exResT;

    // Ops that go through the iterative multiplier.
    function automatic logic isMulOp(aluOpT op);
        return op inside {OpMul, OpMult, OpMultu};
    endfunction

endpackage
